/* Bender.yml */
package:
  name: branchFrontEnd

sources:
  - include_dirs:
      - common
    files:
      - common/isaPkg.sv
      - common/pipePkg.sv
      - bpcu/branchCond.sv
      - bpcu/branchDecode.sv
      - bpcu/pcPipeline.sv
      - bpcu/atomTracker.sv
      - design/branchFrontEnd.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - test/tbBranchFrontEnd.sv

/* bpcu/atomTracker.sv */
`timescale 1ns/100ps
`default_nettype none

module atomTracker (
   input  wire logic            gclk,
   input  wire logic            grst,
   input  wire logic            gena,
   input  wire isaPkg::opcode_t opcode,
   input  wire logic            branchTaken,
   input  wire logic            skipNow,
   output pipePkg::atomPhase_t  atomPhase
);

   logic prevBranch;
   logic breaksNow;
   logic safe;

   // Instructions that may not be split from their successor
   // Masked while the slot is being skipped
   assign breaksNow = ~skipNow & ((opcode == isaPkg::IMM)
                                | (opcode == isaPkg::RTD)
                                | isaPkg::isBru(opcode)
                                | (isaPkg::isBcc(opcode) & branchTaken));

   // The cycle after any taken branch is never a safe border
   assign safe = ~(breaksNow | prevBranch);

   always_ff @(posedge gclk) begin
      if (grst) begin
         prevBranch <= 1'b0;
         atomPhase  <= 2'b00;
      end else if (gena) begin
         prevBranch <= branchTaken;
         // High bit lags, low bit toggles on a safe border
         atomPhase  <= {atomPhase[0], atomPhase[0] ^ safe};
      end
   end

endmodule

`default_nettype wire

/* bpcu/branchCond.sv */
`timescale 1ns/100ps
`default_nettype none

module branchCond (
   input  wire pipePkg::fwdSel_t fwdSel,
   input  wire logic [31:0]      regA,
   input  wire logic [31:0]      aluResult,
   input  wire logic [31:0]      loadData,
   input  wire isaPkg::cond_t    cond,
   output logic                  condMet
);

   logic [31:0] operand;
   logic        isZero;
   logic        isNeg;

   // Operand A forwarding mux
   always_comb begin
      case (fwdSel)
         pipePkg::ALU:     operand = aluResult;
         pipePkg::LOAD:    operand = loadData;
         pipePkg::REGFILE: operand = regA;
         // Unused select falls back to the register file
         default:          operand = regA;
      endcase
   end

   // Base tests, everything else derives from these two
   assign isZero = (operand == 32'd0);
   assign isNeg  = operand[31];

   // Condition select
   always_comb begin
      case (cond)
         isaPkg::EQ: condMet = isZero;
         isaPkg::NE: condMet = ~isZero;
         isaPkg::LT: condMet = isNeg;
         isaPkg::LE: condMet = isNeg | isZero;
         // Strictly positive
         isaPkg::GT: condMet = ~(isNeg | isZero);
         isaPkg::GE: condMet = ~isNeg;
         // Reserved codes never branch
         default:    condMet = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

/* bpcu/branchDecode.sv */
`timescale 1ns/100ps
`default_nettype none

module branchDecode (
   input  wire logic            gclk,
   input  wire logic            grst,
   input  wire logic            gena,
   input  wire isaPkg::opcode_t opcode,
   input  wire isaPkg::regIdx_t rd,
   input  wire isaPkg::regIdx_t ra,
   input  wire logic            condMet,
   output logic                 branchTaken,
   output logic                 skipNow,
   output logic                 skip
);

   logic isRtd;
   logic isBru;
   logic isBcc;
   logic hasDelay;

   // Opcode groups
   assign isRtd = (opcode == isaPkg::RTD);
   assign isBru = isaPkg::isBru(opcode);
   assign isBcc = isaPkg::isBcc(opcode);

   // Return and unconditional always go, conditional only on a met test
   assign branchTaken = isRtd | isBru | (isBcc & condMet);

   // Delay slot marker sits in ra for BRU and in rd for BCC
   // Return always has a delay slot
   assign hasDelay = isRtd
                   | (isBru & ra[isaPkg::DLY_BIT])
                   | (isBcc & rd[isaPkg::DLY_BIT]);

   // Taken without a delay slot kills the instruction behind it
   assign skipNow = branchTaken & ~hasDelay;

   // Skip flag for the next stage
   always_ff @(posedge gclk) begin
      if (grst) begin
         skip <= 1'b0;
      end else if (gena) begin
         skip <= skipNow;
      end
   end

endmodule

`default_nettype wire

/* bpcu/pcPipeline.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module pcPipeline (
   input  wire logic                 gclk,
   input  wire logic                 grst,
   input  wire logic                 gena,
   input  wire logic                 branchTaken,
   input  wire logic [31:0]          aluResult,
   output logic [`FETCH_W-1:0]       fetchAddr,
   output pipePkg::pcWord_t          pc,
   output pipePkg::pcWord_t          pcLink
);

   pipePkg::pcWord_t nextFetch;
   pipePkg::pcWord_t preIpc;
   pipePkg::pcWord_t ipc;

   // Next fetch word
   // Branch target is the ALU result with the byte offset dropped
   always_comb begin
      if (branchTaken) begin
         nextFetch = aluResult[31:2];
      end else begin
         nextFetch = preIpc + 1'b1;
      end
   end

   // Only the cache-visible address bits leave the block
   assign fetchAddr = nextFetch[`FETCH_W-1:0];

   // PC shift chain
   // fetch -> prefetch -> issue -> execute, link holds the old execute PC
   always_ff @(posedge gclk) begin
      if (grst) begin
         preIpc <= `RESET_PC;
         ipc    <= `RESET_PC;
         pc     <= `RESET_PC;
         pcLink <= `RESET_PC;
      end else if (gena) begin
         preIpc <= nextFetch;
         ipc    <= preIpc;
         pc     <= ipc;
         pcLink <= pc;
      end
   end

endmodule

`default_nettype wire

/* common/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Instruction address bits seen by the cache
// The fetch port carries byte-address bits IADDR_W-1 down to 2
`define IADDR_W 24

// Word address loaded into every PC register at reset
`define RESET_PC 30'h0000_0000

// Width of the fetch address port in words
`define FETCH_W (`IADDR_W - 2)

`endif

/* common/isaPkg.sv */
`default_nettype none

package isaPkg;

   // Primary opcode field
   typedef logic [5:0] opcode_t;

   // Unconditional branch, register and immediate forms
   localparam opcode_t BRU_A = 6'o46;
   localparam opcode_t BRU_I = 6'o56;
   // Conditional branch, register and immediate forms
   localparam opcode_t BCC_A = 6'o47;
   localparam opcode_t BCC_I = 6'o57;
   // Return from subroutine, always delayed
   localparam opcode_t RTD   = 6'o55;
   // Immediate prefix, glues itself to the next instruction
   localparam opcode_t IMM   = 6'o54;

   // Branch condition, carried in the low bits of rd
   // Codes 6 and 7 are never taken
   typedef logic [2:0] cond_t;

   localparam cond_t EQ = 3'd0;
   localparam cond_t NE = 3'd1;
   localparam cond_t LT = 3'd2;
   localparam cond_t LE = 3'd3;
   localparam cond_t GT = 3'd4;
   localparam cond_t GE = 3'd5;

   // Register index field
   typedef logic [4:0] regIdx_t;

   // Delay-slot marker bit in rd (BCC) or ra (BRU)
   localparam int DLY_BIT = 4;

   // Opcode group tests
   function automatic logic isBru(opcode_t op);
      return (op == BRU_A) || (op == BRU_I);
   endfunction

   function automatic logic isBcc(opcode_t op);
      return (op == BCC_A) || (op == BCC_I);
   endfunction

endpackage

`default_nettype wire

/* common/pipePkg.sv */
`default_nettype none

package pipePkg;

   // Word address width, byte bits 31 down to 2
   localparam int PC_W = 30;

   // Word-aligned program counter
   typedef logic [PC_W-1:0] pcWord_t;

   // Source select for operand A forwarding
   typedef logic [1:0] fwdSel_t;

   // Register file read
   localparam fwdSel_t REGFILE = 2'd0;
   // Result of the instruction now leaving the ALU
   localparam fwdSel_t ALU     = 2'd1;
   // Data returned by a load
   localparam fwdSel_t LOAD    = 2'd2;

   // Atomic-border phase
   // Bit 0 toggles on each safe border, bit 1 lags bit 0 by one cycle
   typedef logic [1:0] atomPhase_t;

endpackage

`default_nettype wire

/* design/branchFrontEnd.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module branchFrontEnd (
   input  wire logic             gclk,
   input  wire logic             grst,
   input  wire logic             gena,
   input  wire isaPkg::opcode_t  opcode,
   input  wire isaPkg::regIdx_t  rd,
   input  wire isaPkg::regIdx_t  ra,
   input  wire pipePkg::fwdSel_t fwdSel,
   input  wire logic [31:0]      regA,
   input  wire logic [31:0]      aluResult,
   input  wire logic [31:0]      loadData,
   output logic [`FETCH_W-1:0]   fetchAddr,
   output pipePkg::pcWord_t      pc,
   output pipePkg::pcWord_t      pcLink,
   output logic                  skip,
   output pipePkg::atomPhase_t   atomPhase
);

   logic condMet;
   logic branchTaken;
   logic skipNow;

   // Condition code rides in the low bits of rd
   branchCond i_branchCond (
      .fwdSel    (fwdSel),
      .regA      (regA),
      .aluResult (aluResult),
      .loadData  (loadData),
      .cond      (rd[2:0]),
      .condMet   (condMet)
   );

   branchDecode i_branchDecode (
      .gclk        (gclk),
      .grst        (grst),
      .gena        (gena),
      .opcode      (opcode),
      .rd          (rd),
      .ra          (ra),
      .condMet     (condMet),
      .branchTaken (branchTaken),
      .skipNow     (skipNow),
      .skip        (skip)
   );

   // Target comes straight from the ALU result
   pcPipeline i_pcPipeline (
      .gclk        (gclk),
      .grst        (grst),
      .gena        (gena),
      .branchTaken (branchTaken),
      .aluResult   (aluResult),
      .fetchAddr   (fetchAddr),
      .pc          (pc),
      .pcLink      (pcLink)
   );

   atomTracker i_atomTracker (
      .gclk        (gclk),
      .grst        (grst),
      .gena        (gena),
      .opcode      (opcode),
      .branchTaken (branchTaken),
      .skipNow     (skipNow),
      .atomPhase   (atomPhase)
   );

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
bpcu/branchCond.sv
bpcu/branchDecode.sv
bpcu/pcPipeline.sv
bpcu/atomTracker.sv
design/branchFrontEnd.sv
test/tbBranchFrontEnd.sv

/* test/tbBranchFrontEnd.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module tbBranchFrontEnd;

   // Test lengths in cycles
   localparam int RST_CYC = 16;
   localparam int SEQ_LEN = 20;
   localparam int UNC_LEN = 30;
   localparam int RND_LEN = 200;
   // Sum of all tests and reset, two settling cycles per test, 50% margin on top
   localparam int LIMIT = (RST_CYC + SEQ_LEN + UNC_LEN + 3 * RND_LEN + 5 * 2) * 3 / 2;

   logic gclk = 1'b0;
   logic grst, gena;
   isaPkg::opcode_t opcode;
   isaPkg::regIdx_t rd, ra;
   pipePkg::fwdSel_t fwdSel;
   logic [31:0] regA, aluResult, loadData;
   logic [`FETCH_W-1:0] fetchAddr;
   pipePkg::pcWord_t pc, pcLink;
   logic skip;
   pipePkg::atomPhase_t atomPhase;

   // Model state after the last enabled edge
   pipePkg::pcWord_t mPre, mIpc, mPc, mLink;
   logic mSkip, mPrev;
   pipePkg::atomPhase_t mPhase;

   logic [31:0] seed = 32'hd5c0_323b;
   int errorCount = 0;
   int checkCount = 0;
   int testsPassed = 0;
   int testsFailed = 0;
   int cycleCount = 0;

   branchFrontEnd i_dut (.*);

   initial forever #4 gclk = ~gclk;

   // LCG step
   function automatic logic [31:0] rnd();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // Zero and negative values show up often
   function automatic logic [31:0] pickOperand();
      logic [31:0] r;
      logic [31:0] v;
      r = rnd();
      if (r[30:29] == 2'd0) return 32'd0;
      v = rnd();
      // Force the sign bit
      if (r[30:29] == 2'd1) return {1'b1, v[30:0]};
      return v;
   endfunction

   // Expected fetch address for the current inputs
   // Model state moves forward only when the enable is high
   function automatic logic [`FETCH_W-1:0] refStep(input isaPkg::opcode_t op,
         input isaPkg::regIdx_t rdV, input isaPkg::regIdx_t raV,
         input pipePkg::fwdSel_t sel, input logic [31:0] rA, input logic [31:0] alu,
         input logic [31:0] ld, input logic ena);
      logic [31:0] opnd;
      logic cmet, isB, isC, isR, taken, delay, skipN, brk, safe;
      pipePkg::pcWord_t nxt;
      // Select 3 reads the register file like select 0
      opnd = (sel == 2'd1) ? alu : (sel == 2'd2) ? ld : rA;
      case (rdV[2:0])
         3'd0: cmet = (opnd == 0);
         3'd1: cmet = (opnd != 0);
         3'd2: cmet = opnd[31];
         3'd3: cmet = opnd[31] || (opnd == 0);
         3'd4: cmet = !opnd[31] && (opnd != 0);
         3'd5: cmet = !opnd[31];
         default: cmet = 1'b0;
      endcase
      isB = (op == isaPkg::BRU_A) || (op == isaPkg::BRU_I);
      isC = (op == isaPkg::BCC_A) || (op == isaPkg::BCC_I);
      isR = (op == isaPkg::RTD);
      taken = isB || isR || (isC && cmet);
      delay = isR || (isB && raV[4]) || (isC && rdV[4]);
      skipN = taken && !delay;
      brk = !skipN && ((op == isaPkg::IMM) || isR || isB || (isC && taken));
      safe = !(brk || mPrev);
      nxt = taken ? alu[31:2] : mPre + 1;
      if (ena) begin
         mLink = mPc;
         mPc = mIpc;
         mIpc = mPre;
         mPre = nxt;
         mSkip = skipN;
         mPrev = taken;
         mPhase = {mPhase[0], mPhase[0] ^ safe};
      end
      return nxt[`FETCH_W-1:0];
   endfunction

   task automatic checkPc(input string name, input pipePkg::pcWord_t expV,
         input pipePkg::pcWord_t actV);
      checkCount++;
      if (expV !== actV) begin
         errorCount++;
         $display("MISMATCH %s expected %h actual %h", name, expV, actV);
      end
   endtask

   task automatic checkFetch(input string name, input logic [`FETCH_W-1:0] expV,
         input logic [`FETCH_W-1:0] actV);
      checkCount++;
      if (expV !== actV) begin
         errorCount++;
         $display("MISMATCH %s expected %h actual %h", name, expV, actV);
      end
   endtask

   task automatic checkBit(input string name, input logic expV, input logic actV);
      checkCount++;
      if (expV !== actV) begin
         errorCount++;
         $display("MISMATCH %s expected %h actual %h", name, expV, actV);
      end
   endtask

   task automatic checkPhase(input string name, input pipePkg::atomPhase_t expV,
         input pipePkg::atomPhase_t actV);
      checkCount++;
      if (expV !== actV) begin
         errorCount++;
         $display("MISMATCH %s expected %h actual %h", name, expV, actV);
      end
   endtask

   // Mid-cycle checker while inputs and registers are settled
   always @(negedge gclk) begin
      if (grst) begin
         {mPre, mIpc, mPc, mLink} = {4{`RESET_PC}};
         {mSkip, mPrev, mPhase} = 4'b0;
      end else begin
         // Registered outputs against the model before it steps
         checkPc("pc", mPc, pc);
         checkPc("pcLink", mLink, pcLink);
         checkBit("skip", mSkip, skip);
         checkPhase("atomPhase", mPhase, atomPhase);
         checkFetch("fetchAddr",
            refStep(opcode, rd, ra, fwdSel, regA, aluResult, loadData, gena), fetchAddr);
      end
   end

   // Cycle counter for the timeout
   always @(posedge gclk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= LIMIT) begin
         $display("Run timed out after %0d cycles", cycleCount);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // One cycle of stimulus, operands and forward select are random
   task automatic applyInputs(input isaPkg::opcode_t op, input isaPkg::regIdx_t rdV,
         input isaPkg::regIdx_t raV, input logic ena);
      @(posedge gclk);
      opcode <= op;
      rd <= rdV;
      ra <= raV;
      gena <= ena;
      fwdSel <= rnd() >> 30;
      regA <= pickOperand();
      aluResult <= pickOperand();
      loadData <= pickOperand();
   endtask

   // Scores the test once the last inputs have reached the registers
   task automatic finishTest(input string name, input int errsBefore);
      repeat (2) @(negedge gclk);
      #1;
      if (errorCount == errsBefore) testsPassed++;
      else testsFailed++;
      $display("%s: %s, %0d mismatches", name, (errorCount == errsBefore) ? "ok" : "bad",
         errorCount - errsBefore);
   endtask

   // Random opcode from branches, IMM and plain instructions
   function automatic isaPkg::opcode_t pickOpcode();
      case (rnd() % 7)
         0: return isaPkg::IMM;
         1: return isaPkg::BRU_A;
         2: return isaPkg::BRU_I;
         3: return isaPkg::BCC_A;
         4: return isaPkg::BCC_I;
         5: return isaPkg::RTD;
         default: return 6'o10;
      endcase
   endfunction

   initial begin
      int errs;
      {grst, gena, opcode, rd, ra, fwdSel} = {1'b1, 1'b0, 6'o0, 5'd0, 5'd0, 2'd0};
      {regA, aluResult, loadData} = '0;
      repeat (RST_CYC) @(posedge gclk);
      grst <= 1'b0;
      // Plain opcodes only
      errs = errorCount;
      for (int i = 0; i < SEQ_LEN; i++) applyInputs(6'o00, 5'd0, 5'd0, 1'b1);
      finishTest("sequential fetch", errs);
      // BRU without and with delay slot, then RTD, plain fillers between
      errs = errorCount;
      for (int i = 0; i < UNC_LEN; i++) begin
         case (i % 6)
            0: applyInputs(isaPkg::BRU_A, 5'd0, 5'd0, 1'b1);
            2: applyInputs(isaPkg::BRU_I, 5'd0, 5'd16, 1'b1);
            4: applyInputs(isaPkg::RTD, 5'd0, 5'd0, 1'b1);
            default: applyInputs(6'o00, 5'd0, 5'd0, 1'b1);
         endcase
      end
      finishTest("unconditional and return", errs);
      // Mostly BCC in both forms, random cond and delay bit in rd
      errs = errorCount;
      for (int i = 0; i < RND_LEN; i++)
         applyInputs(rnd() % 4 == 0 ? 6'o10 : isaPkg::BCC_A | (rnd() & 6'o10),
            rnd(), rnd(), 1'b1);
      finishTest("conditional branches", errs);
      errs = errorCount;
      for (int i = 0; i < RND_LEN; i++) applyInputs(pickOpcode(), rnd(), rnd(), 1'b1);
      finishTest("atomic phase", errs);
      // Enable drops about half the time
      errs = errorCount;
      for (int i = 0; i < RND_LEN; i++) applyInputs(pickOpcode(), rnd(), rnd(), rnd() >> 31);
      finishTest("stall", errs);
      $display("Tests passed %0d, failed %0d, checks %0d, mismatches %0d",
         testsPassed, testsFailed, checkCount, errorCount);
      if (testsFailed == 0 && errorCount == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
